// File: hw/kd_defs.svh
/*
  Build-time sizes of the KD-tree search engine.
  Override them on the compile line to change the tree.
  KD_DEPTH must be at least 1, and KD_COMPONENTS at least 2.
  A dimension field wider than needed routes the unused codes right.
*/

`ifndef KD_DEFS_SVH
`define KD_DEFS_SVH

// Number of internal levels, giving 2**KD_DEPTH - 1 nodes and 2**KD_DEPTH leaves
`define KD_DEPTH 4

// Components per image patch
`define KD_COMPONENTS 5

// Bits per unsigned patch component, which is also the threshold width
`define KD_COMP_WIDTH 11

`endif

// File: hw/kd_pkg.sv
/*
  Shared widths and types for the KD-tree search engine.
  Everything here is derived from the defines in kd_defs.svh.
  Component 0 of a patch sits in the low bits.
*/

`include "kd_defs.svh"

package kd_pkg;

  localparam int DEPTH       = `KD_DEPTH;
  localparam int NODE_COUNT  = (1 << `KD_DEPTH) - 1;  // Internal nodes in heap order
  localparam int LEAF_COUNT  = 1 << `KD_DEPTH;
  localparam int NODE_ADDR_W = $clog2(NODE_COUNT + 1);  // One spare code marks a full tree
  localparam int DIM_W       = $clog2(`KD_COMPONENTS);

  typedef logic [NODE_ADDR_W-1:0]   node_addr_t;
  typedef logic [`KD_DEPTH-1:0]     leaf_index_t;
  typedef logic [`KD_COMP_WIDTH-1:0] comp_t;
  typedef comp_t [`KD_COMPONENTS-1:0] patch_t;
  typedef logic [DIM_W-1:0]         dim_t;
  typedef logic [NODE_COUNT-1:0]    tree_sel_t;  // One write enable per node
  typedef logic [LEAF_COUNT-1:0]    leaf_vec_t;  // One bit per leaf, also used per level

  // Dimension in the high bits, threshold in the low bits
  typedef struct packed {
    dim_t  dim;
    comp_t thresh;
  } node_word_t;

endpackage

// File: hw/kd_internal_node.sv
/*
  One internal node of the KD-tree.
  A valid query goes left when its selected component is strictly below
  the threshold, otherwise right, so ties go right.
  A stored dimension at or above the component count always routes right.
*/

`timescale 1ns/10ps

module kd_internal_node import kd_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wen,
  input  node_word_t wdata,
  input  logic       valid,
  input  patch_t     patch_in,
  output logic       valid_left,
  output logic       valid_right
);

  node_word_t node_q;  // Split dimension and threshold of this node
  comp_t      sel_comp;
  logic       go_left;

  // Node word is loaded once per tree load and then held
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      node_q <= '0;
    end else if (wen) begin
      node_q <= wdata;
    end
  end

  always_comb begin
    sel_comp = '0;
    go_left  = 1'b0;
    // Out-of-range dimensions leave go_left low and fall through to the right child
    if (node_q.dim < `KD_COMPONENTS) begin
      sel_comp = patch_in[node_q.dim];
      go_left  = sel_comp < node_q.thresh;  // Strict compare sends a tie right
    end
  end

  // Exactly one child sees a valid query, none when the slot is empty
  assign valid_left  = valid & go_left;
  assign valid_right = valid & ~go_left;

endmodule

// File: hw/kd_node_loader.sv
/*
  Write address counter and one-hot decoder for loading node words.
  Words arrive in heap order, one per load_valid cycle, starting at node 0.
  load_start restarts at node 0 and suppresses any write in its own cycle.
  Writes after the last node are dropped until the next load_start.
*/

`timescale 1ns/10ps

module kd_node_loader import kd_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      load_start,
  input  logic      load_valid,
  output tree_sel_t node_wen
);

  localparam node_addr_t LAST_ADDR = node_addr_t'(NODE_COUNT);  // First code past the tree

  node_addr_t addr_q;  // Node that the next load_valid writes
  logic       wr_en;

  assign wr_en = load_valid & ~load_start;  // Restart wins over a write

  always_ff @(posedge clk) begin
    if (!rst_n || load_start) begin
      addr_q <= '0;
    end else if (wr_en && addr_q != LAST_ADDR) begin
      addr_q <= addr_q + 1'b1;  // Saturates at LAST_ADDR, so extra words go nowhere
    end
  end

  // Address 0 is the root and a real node here
  always_comb begin
    node_wen = '0;
    for (int k = 0; k < NODE_COUNT; k++) begin
      if (wr_en && addr_q == node_addr_t'(k)) begin
        node_wen[k] = 1'b1;
      end
    end
  end

endmodule

// File: hw/kd_tree_levels.sv
/*
  The node array of the KD-tree, built level by level.
  Each level is followed by a register on the valid vector and the patch,
  so one query can enter per cycle and up to DEPTH are in flight.
  Node loads are not pipelined and take effect on the next edge in every level.
  Bit p of leaf_onehot is leaf p, counted left to right.
*/

`timescale 1ns/10ps

module kd_tree_levels import kd_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  tree_sel_t  node_wen,
  input  node_word_t load_data,
  input  patch_t     patch_in,
  input  logic       search_valid,
  output leaf_vec_t  leaf_onehot
);

  // Inputs seen by each level; only the low 2**i bits of lvl_valid[i] matter
  wire leaf_vec_t lvl_valid [DEPTH+1];
  wire patch_t    lvl_patch [DEPTH];

  // The root works straight off the ports
  assign lvl_valid[0] = leaf_vec_t'(search_valid);
  assign lvl_patch[0] = patch_in;

  for (genvar i = 0; i < DEPTH; i++) begin : g_level
    localparam int BASE  = (1 << i) - 1;  // Heap index of the leftmost node on this level
    localparam int WIDTH = 1 << (i + 1);  // Children produced by this level

    wire  [WIDTH-1:0] child_valid;
    logic [WIDTH-1:0] valid_q;

    for (genvar j = 0; j < (1 << i); j++) begin : g_node
      // Node BASE+j feeds heap children 2k+1 and 2k+2, which are bits 2j and 2j+1 below
      kd_internal_node u_node (
        .clk         (clk),
        .rst_n       (rst_n),
        .wen         (node_wen[BASE+j]),
        .wdata       (load_data),
        .valid       (lvl_valid[i][j]),
        .patch_in    (lvl_patch[i]),
        .valid_left  (child_valid[2*j]),
        .valid_right (child_valid[2*j+1])
      );
    end

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        valid_q <= '0;
      end else begin
        valid_q <= child_valid;  // At most one bit set per query
      end
    end

    assign lvl_valid[i+1] = leaf_vec_t'(valid_q);

    // The patch travels alongside its valid bit, but the leaves have no use for it
    if (i < DEPTH - 1) begin : g_patch
      patch_t patch_q;

      always_ff @(posedge clk) begin
        if (!rst_n) begin
          patch_q <= '0;
        end else begin
          patch_q <= lvl_patch[i];
        end
      end

      assign lvl_patch[i+1] = patch_q;
    end
  end

  assign leaf_onehot = lvl_valid[DEPTH];  // Last level already spans every leaf

endmodule

// File: hw/kd_leaf_encoder.sv
/*
  Turns the one-hot leaf vector into a leaf number.
  Purely combinational. The input is one-hot or zero by construction,
  so several set bits are not detected and would OR their indices.
*/

`timescale 1ns/10ps

module kd_leaf_encoder import kd_pkg::*; (
  input  leaf_vec_t   leaf_onehot,
  output leaf_index_t leaf_index,
  output logic        leaf_valid
);

  // OR of the positions of set bits, which is the position itself for a one-hot input
  always_comb begin
    leaf_index = '0;
    for (int p = 0; p < LEAF_COUNT; p++) begin
      if (leaf_onehot[p]) begin
        leaf_index = leaf_index | leaf_index_t'(p);
      end
    end
  end

  assign leaf_valid = |leaf_onehot;  // Index stays 0 when this is low

endmodule

// File: hw/kd_search_top.sv
/*
  Top of the pipelined KD-tree search engine.
  Load the tree first, then launch one patch per search_valid cycle.
  Results appear DEPTH cycles after launch, in order, with no back-pressure.
  Reloading while queries are in flight gives undefined leaves.
*/

`timescale 1ns/10ps

module kd_search_top import kd_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        load_start,
  input  logic        load_valid,
  input  node_word_t  load_data,
  input  logic        search_valid,
  input  patch_t      patch_in,
  output logic        leaf_valid,
  output leaf_index_t leaf_index
);

  tree_sel_t node_wen;     // Node picked by the current load strobe
  leaf_vec_t leaf_onehot;  // Leaf reached by the query leaving the last level

  kd_node_loader u_loader (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_start (load_start),
    .load_valid (load_valid),
    .node_wen   (node_wen)
  );

  kd_tree_levels u_tree (
    .clk          (clk),
    .rst_n        (rst_n),
    .node_wen     (node_wen),
    .load_data    (load_data),
    .patch_in     (patch_in),
    .search_valid (search_valid),
    .leaf_onehot  (leaf_onehot)
  );

  kd_leaf_encoder u_encoder (
    .leaf_onehot (leaf_onehot),
    .leaf_index  (leaf_index),
    .leaf_valid  (leaf_valid)
  );

endmodule

// File: verification/tb_kd_search.sv
/*
  Self-checking testbench for kd_search_top.
  Node words, patches and expected leaves come from the pattern file,
  which is written for depth 4 and five components.
  Run from the project root so that the pattern file path resolves.
*/

`timescale 1ns/10ps

`include "kd_defs.svh"

module tb_kd_search import kd_pkg::*; ();

  localparam string PATTERN_FILE = "verification/kd_search_patterns.txt";
  localparam int    MAX_QUERIES  = 32;
  localparam int    DRAIN_LIMIT  = 4 * DEPTH + 20;  // Cycles the pipe gets to empty

  logic        clk = 1'b0;
  logic        rst_n;
  logic        load_start;
  logic        load_valid;
  node_word_t  load_data;
  logic        search_valid;
  patch_t      patch_in;
  logic        leaf_valid;
  leaf_index_t leaf_index;

  node_word_t n_set [NODE_COUNT];       // Tree loaded first
  node_word_t r_set [NODE_COUNT];       // Tree for the reload check
  node_word_t tree_words [NODE_COUNT];  // What the DUT holds right now
  patch_t     q_patch [MAX_QUERIES];
  int         q_leaf [MAX_QUERIES];
  int         n_cnt = 0;
  int         r_cnt = 0;
  int         q_cnt = 0;
  int         exp_leaf_q [$];   // Expected leaves, oldest first
  int         exp_stamp_q [$];  // Cycle count when each query was driven
  int         cyc = 0;
  int         errors = 0;
  int         file_errors = 0;
  int         timeouts = 0;

  always #50 clk = ~clk;  // 100 ns period

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  kd_search_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_start   (load_start),
    .load_valid   (load_valid),
    .load_data    (load_data),
    .search_valid (search_valid),
    .patch_in     (patch_in),
    .leaf_valid   (leaf_valid),
    .leaf_index   (leaf_index)
  );

  // Reference walk down the loaded tree, heap children 2k+1 and 2k+2
  function automatic int route_leaf(input patch_t p);
    int k;
    k = 0;
    for (int lvl = 0; lvl < DEPTH; lvl++) begin
      if (tree_words[k].dim >= `KD_COMPONENTS) begin
        k = 2 * k + 2;  // Unused dimension codes go right
      end else if (p[tree_words[k].dim] < tree_words[k].thresh) begin
        k = 2 * k + 1;
      end else begin
        k = 2 * k + 2;  // A tie goes right
      end
    end
    return k - NODE_COUNT;
  endfunction

  task automatic end_run();
    $display("Error counts: %0d result, %0d pattern file, %0d timeout",
             errors, file_errors, timeouts);
    if (errors + file_errors + timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  task automatic read_patterns();
    int         fd;
    int         n;
    int         d;
    int         t;
    int         c0, c1, c2, c3, c4;
    int         leaf;
    string      line;
    string      kind;
    node_word_t w;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      file_errors++;
      $display("Could not open %s for reading", PATTERN_FILE);
    end else begin
      while (!$feof(fd)) begin
        n    = $fgets(line, fd);
        kind = "";
        if (n != 0) begin
          n = $sscanf(line, "%s", kind);  // Comment and blank lines match no kind
        end
        if (kind == "N" || kind == "R") begin
          n        = $sscanf(line, "%s %d %d", kind, d, t);
          w.dim    = dim_t'(d);
          w.thresh = comp_t'(t);
          if (kind == "N" && n_cnt < NODE_COUNT) n_set[n_cnt] = w;
          if (kind == "R" && r_cnt < NODE_COUNT) r_set[r_cnt] = w;
          if (kind == "N") n_cnt++;
          else r_cnt++;
        end else if (kind == "Q" && q_cnt < MAX_QUERIES) begin
          n = $sscanf(line, "%s %d %d %d %d %d %d", kind, c0, c1, c2, c3, c4, leaf);
          q_patch[q_cnt] = {comp_t'(c4), comp_t'(c3), comp_t'(c2), comp_t'(c1), comp_t'(c0)};
          q_leaf[q_cnt]  = leaf;
          q_cnt++;
        end
      end
      $fclose(fd);
      if (n_cnt != NODE_COUNT || r_cnt != NODE_COUNT || q_cnt == 0) begin
        file_errors++;
        $display("Pattern file has %0d N words, %0d R words and %0d queries, each tree needs %0d",
                 n_cnt, r_cnt, q_cnt, NODE_COUNT);
      end
    end
  endtask

  task automatic load_tree(input bit reload);
    @(negedge clk);
    load_start = 1'b1;  // Write address back to the root
    @(negedge clk);
    load_start = 1'b0;
    for (int k = 0; k < NODE_COUNT; k++) begin
      tree_words[k] = reload ? r_set[k] : n_set[k];
      load_valid    = 1'b1;
      load_data     = tree_words[k];
      @(negedge clk);
    end
    load_valid = 1'b0;
    load_data  = '0;
  endtask

  // Drives one query, then leaves the input idle for gap cycles
  task automatic launch(input patch_t p, input int leaf, input int gap);
    @(negedge clk);
    search_valid = 1'b1;
    patch_in     = p;
    exp_leaf_q.push_back(leaf);
    exp_stamp_q.push_back(cyc);  // Sampled by the DUT at the coming rising edge
    repeat (gap) begin
      @(negedge clk);
      search_valid = 1'b0;
      patch_in     = '0;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(negedge clk);
    search_valid = 1'b0;
    patch_in     = '0;
    while (exp_leaf_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_leaf_q.size() != 0) begin
      timeouts++;
      $display("Timeout: no leaf_valid for the query launched at cycle %0d", exp_stamp_q[0]);
      exp_leaf_q.delete();
      exp_stamp_q.delete();
    end
  endtask

  // Outputs come straight from registers, so they are settled at the falling edge
  always @(negedge clk) begin : check_results
    int exp_leaf;
    int stamp;
    if (leaf_valid === 1'b1) begin
      assert (exp_leaf_q.size() != 0) else begin
        errors++;
        $display("Extra leaf_valid pulse at %0t with no query in flight", $time);
      end
      if (exp_leaf_q.size() != 0) begin
        exp_leaf = exp_leaf_q.pop_front();
        stamp    = exp_stamp_q.pop_front();
        assert (leaf_index == leaf_index_t'(exp_leaf)) else begin
          errors++;
          $display("error at %0t: leaf_index %0d, expected %0d", $time, leaf_index, exp_leaf);
        end
        assert (cyc - stamp == DEPTH) else begin
          errors++;
          $display("error at %0t: leaf_valid %0d cycles after launch, expected %0d",
                   $time, cyc - stamp, DEPTH);
        end
      end
    end else begin
      assert (leaf_valid === 1'b0) else begin
        errors++;
        $display("error at %0t: leaf_valid is %b, expected 0", $time, leaf_valid);
      end
      assert (leaf_index == '0) else begin
        errors++;
        $display("error at %0t: leaf_index %0d while leaf_valid is low", $time, leaf_index);
      end
      // An overdue query means its pulse was lost
      if (exp_stamp_q.size() != 0) begin
        assert (cyc - exp_stamp_q[0] < DEPTH) else begin
          errors++;
          $display("Missing leaf_valid at %0t for the query launched at cycle %0d",
                   $time, exp_stamp_q[0]);
          exp_leaf = exp_leaf_q.pop_front();
          stamp    = exp_stamp_q.pop_front();
        end
      end
    end
  end

  // Reset, first tree, single, back-to-back and gapped queries, then the reload
  task automatic run_sequence();
    // Any leaf_valid during reset shows up as an extra pulse in the checker
    repeat (10) begin
      @(negedge clk);
    end
    rst_n = 1'b1;
    repeat (3) begin
      @(negedge clk);
    end
    load_tree(1'b0);
    for (int i = 0; i < q_cnt; i++) begin
      assert (route_leaf(q_patch[i]) == q_leaf[i]) else begin
        file_errors++;
        $display("error at %0t: pattern file expects leaf %0d for query %0d, routing gives %0d",
                 $time, q_leaf[i], i, route_leaf(q_patch[i]));
      end
    end
    for (int i = 0; i < q_cnt; i++) begin
      launch(q_patch[i], q_leaf[i], 0);
      wait_drain();  // One query alone in the pipe
    end
    for (int i = 0; i < q_cnt; i++) begin
      launch(q_patch[i], q_leaf[i], 0);  // A new query every cycle
    end
    wait_drain();
    for (int i = 0; i < q_cnt; i++) begin
      launch(q_patch[i], q_leaf[i], $urandom % 4);
    end
    wait_drain();
    // Same patches against the second tree
    load_tree(1'b1);
    for (int i = 0; i < q_cnt; i++) begin
      launch(q_patch[i], route_leaf(q_patch[i]), i % 2);
    end
    wait_drain();
    repeat (DEPTH + 2) begin
      @(negedge clk);  // A late pulse here would be extra
    end
  endtask

  initial begin : run_tests
    void'($urandom(32'h11e0_f9fc));
    rst_n        = 1'b0;
    load_start   = 1'b0;
    load_valid   = 1'b0;
    load_data    = '0;
    search_valid = 1'b0;
    patch_in     = '0;
    read_patterns();
    if (file_errors == 0) begin
      run_sequence();
    end
    end_run();
  end

endmodule

// File: verification/kd_search_patterns.txt
# N and R lines: <kind> <dim> <threshold> per node in heap order; R is the reload tree
# Q lines: <kind> <c0> <c1> <c2> <c3> <c4> <expected leaf on the N tree>
N 0 1000
N 1 500
N 1 1500
N 2 300
N 2 700
N 2 1200
N 2 1800
N 3 100
N 3 400
N 4 600
N 4 900
N 3 1100
N 3 1300
N 5 0
N 4 2000
Q 200 100 50 50 0 0
Q 0 0 0 100 0 1
Q 10 499 1000 200 0 2
Q 0 0 300 400 0 3
Q 700 900 100 0 599 4
Q 999 500 700 50 50 6
Q 800 800 800 0 900 7
Q 1000 0 0 1100 0 9
Q 1100 100 1300 1299 0 10
Q 1200 1600 100 0 0 13
Q 1500 1500 1800 0 2000 15
Q 1500 1500 1800 0 1999 14
R 4 1024
R 0 512
R 3 1536
R 1 256
R 2 768
R 0 1280
R 4 1792
R 3 128
R 1 384
R 2 640
R 0 896
R 1 1152
R 4 1408
R 2 1664
R 7 0

// File: tb.f
+incdir+hw
hw/kd_pkg.sv
hw/kd_internal_node.sv
hw/kd_node_loader.sv
hw/kd_tree_levels.sv
hw/kd_leaf_encoder.sv
hw/kd_search_top.sv
verification/tb_kd_search.sv

// File: Bender.yml
package:
  name: kd_search

sources:
  - include_dirs:
      - hw
    files:
      - hw/kd_pkg.sv
      - hw/kd_internal_node.sv
      - hw/kd_node_loader.sv
      - hw/kd_tree_levels.sv
      - hw/kd_leaf_encoder.sv
      - hw/kd_search_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verification/tb_kd_search.sv
